// File: hw/rv32_pkg.sv
package rv32_pkg;

  // Major opcodes, RV32I base encoding
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    MISCMEM = 7'b0001111,
    SYSTEM  = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  // funct3 of IMMED and REGREG
  typedef enum logic [2:0] {
    F3_ADD = 3'd0, F3_SLL = 3'd1, F3_SLT = 3'd2, F3_SLTU = 3'd3,
    F3_XOR = 3'd4, F3_SR  = 3'd5, F3_OR  = 3'd6, F3_AND  = 3'd7
  } alu_f3_t;

  typedef enum logic [2:0] {
    BEQ = 3'd0, BNE = 3'd1, BLT = 3'd4, BGE = 3'd5, BLTU = 3'd6, BGEU = 3'd7
  } branch_t;

  // Stores reuse LB/LH/LW for SB/SH/SW
  typedef enum logic [2:0] {
    LB = 3'd0, LH = 3'd1, LW = 3'd2, LBU = 3'd4, LHU = 3'd5
  } load_t;

  // Operand and write-back selects
  localparam logic [1:0] A_RS1  = 2'd0;
  localparam logic [1:0] A_PC   = 2'd1;
  localparam logic [1:0] B_RS2  = 2'd0;
  localparam logic [1:0] B_IMM  = 2'd1;
  localparam logic [2:0] W_LOAD = 3'd0;
  localparam logic [2:0] W_PC4  = 3'd1;
  localparam logic [2:0] W_IMM  = 3'd2;
  localparam logic [2:0] W_ALU  = 3'd3;

  // jal x0, 0
  localparam logic [31:0] HALT_INSN = 32'h0000_006f;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } rtype_t;

  typedef struct packed {
    logic [11:0] imm11_00;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm11_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm04_00;
    opcode_t    opcode;
  } stype_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_05;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm04_01;
    logic       imm11;
    opcode_t    opcode;
  } sbtype_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    opcode_t     opcode;
  } utype_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_01;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } ujtype_t;

  typedef union packed {
    rtype_t  r;
    itype_t  i;
    stype_t  s;
    sbtype_t sb;
    utype_t  u;
    ujtype_t uj;
  } instr_u;

  typedef struct packed {
    alu_op_t     alu_op;
    logic [1:0]  alu_a_sel;
    logic [1:0]  alu_b_sel;
    logic [2:0]  w_sel;
    logic        wen;
    logic        dren;
    logic        dwen;
    load_t       load_type;
    logic        branch;
    branch_t     branch_type;
    logic        jump;
    logic        j_sel;
    logic        halt;
    logic        illegal;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
  } ctrl_t;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

endpackage

// File: hw/control_unit.sv
module control_unit import rv32_pkg::*; (
  input  instr_u instr_i,
  output ctrl_t  ctrl_o
);

  opcode_t     opcode;
  alu_f3_t     f3;
  alu_op_t     arith_op;
  logic        bit30;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign opcode = instr_i.r.opcode;
  assign f3     = alu_f3_t'(instr_i.r.funct3);
  assign bit30  = instr_i.r.funct7[5];

  // Immediates, one per format
  assign imm_i = {{20{instr_i.i.imm11_00[11]}}, instr_i.i.imm11_00};
  assign imm_s = {{20{instr_i.s.imm11_05[6]}}, instr_i.s.imm11_05, instr_i.s.imm04_00};
  assign imm_b = {{19{instr_i.sb.imm12}}, instr_i.sb.imm12, instr_i.sb.imm11,
                  instr_i.sb.imm10_05, instr_i.sb.imm04_01, 1'b0};
  assign imm_u = {instr_i.u.imm31_12, 12'b0};
  assign imm_j = {{11{instr_i.uj.imm20}}, instr_i.uj.imm20, instr_i.uj.imm19_12,
                  instr_i.uj.imm11, instr_i.uj.imm10_01, 1'b0};

  // ALU operation for IMMED and REGREG
  always_comb begin
    case (f3)
      F3_ADD:  arith_op = (opcode == REGREG && bit30) ? ALU_SUB : ALU_ADD;
      F3_SLL:  arith_op = ALU_SLL;
      F3_SLT:  arith_op = ALU_SLT;
      F3_SLTU: arith_op = ALU_SLTU;
      F3_XOR:  arith_op = ALU_XOR;
      F3_SR:   arith_op = bit30 ? ALU_SRA : ALU_SRL;
      F3_OR:   arith_op = ALU_OR;
      F3_AND:  arith_op = ALU_AND;
      default: arith_op = ALU_ADD;
    endcase
  end

  always_comb begin
    ctrl_o             = '0;
    ctrl_o.rs1         = instr_i.r.rs1;
    ctrl_o.rs2         = instr_i.r.rs2;
    ctrl_o.rd          = instr_i.r.rd;
    ctrl_o.load_type   = load_t'(instr_i.i.funct3);
    ctrl_o.branch_type = branch_t'(instr_i.sb.funct3);
    ctrl_o.halt        = (instr_i == HALT_INSN);
    ctrl_o.alu_op      = ALU_ADD;
    ctrl_o.alu_a_sel   = A_RS1;
    ctrl_o.alu_b_sel   = B_IMM;
    ctrl_o.w_sel       = W_ALU;
    case (opcode)
      LUI: begin
        ctrl_o.wen   = 1'b1;
        ctrl_o.w_sel = W_IMM;
        ctrl_o.imm   = imm_u;
      end
      AUIPC: begin
        ctrl_o.wen       = 1'b1;
        ctrl_o.alu_a_sel = A_PC;
        ctrl_o.imm       = imm_u;
      end
      JAL: begin
        ctrl_o.wen   = 1'b1;
        ctrl_o.jump  = 1'b1;
        ctrl_o.j_sel = 1'b1;
        ctrl_o.w_sel = W_PC4;
        ctrl_o.imm   = imm_j;
      end
      // Target rs1+imm comes from the ALU
      JALR: begin
        ctrl_o.wen   = 1'b1;
        ctrl_o.jump  = 1'b1;
        ctrl_o.w_sel = W_PC4;
        ctrl_o.imm   = imm_i;
      end
      BRANCH: begin
        ctrl_o.branch    = 1'b1;
        ctrl_o.alu_b_sel = B_RS2;
        ctrl_o.imm       = imm_b;
      end
      LOAD: begin
        ctrl_o.wen   = 1'b1;
        ctrl_o.dren  = 1'b1;
        ctrl_o.w_sel = W_LOAD;
        ctrl_o.imm   = imm_i;
      end
      STORE: begin
        ctrl_o.dwen = 1'b1;
        ctrl_o.imm  = imm_s;
      end
      IMMED: begin
        ctrl_o.wen    = 1'b1;
        ctrl_o.alu_op = arith_op;
        ctrl_o.imm    = imm_i;
      end
      // funct7[0] marks the M extension, not supported
      REGREG: begin
        ctrl_o.wen       = 1'b1;
        ctrl_o.alu_op    = arith_op;
        ctrl_o.alu_b_sel = B_RS2;
        ctrl_o.illegal   = instr_i.r.funct7[0];
      end
      // FENCE runs as a no-op
      MISCMEM: ctrl_o.imm = imm_i;
      default: ctrl_o.illegal = 1'b1;
    endcase
  end

endmodule

// File: hw/alu.sv
module alu import rv32_pkg::*; (
  input  alu_op_t     op_i,
  input  logic [31:0] a_i,
  input  logic [31:0] b_i,
  input  branch_t     branch_type_i,
  input  logic [31:0] rs1_i,
  input  logic [31:0] rs2_i,
  output logic [31:0] result_o,
  output logic        br_taken_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SLT:  result_o = {31'b0, $signed(a_i) < $signed(b_i)};
      ALU_SLTU: result_o = {31'b0, a_i < b_i};
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      ALU_OR:   result_o = a_i | b_i;
      ALU_AND:  result_o = a_i & b_i;
      default:  result_o = a_i + b_i;
    endcase
  end

  // Branch compare on the raw register values
  always_comb begin
    case (branch_type_i)
      BEQ:     br_taken_o = (rs1_i == rs2_i);
      BNE:     br_taken_o = (rs1_i != rs2_i);
      BLT:     br_taken_o = ($signed(rs1_i) < $signed(rs2_i));
      BGE:     br_taken_o = ($signed(rs1_i) >= $signed(rs2_i));
      BLTU:    br_taken_o = (rs1_i < rs2_i);
      BGEU:    br_taken_o = (rs1_i >= rs2_i);
      default: br_taken_o = 1'b0;
    endcase
  end

endmodule

// File: hw/reg_file.sv
module reg_file (
  input  logic        clk,
  input  logic        reset_i,
  input  logic [4:0]  rs1_i,
  input  logic [4:0]  rs2_i,
  input  logic [4:0]  rd_i,
  input  logic        we_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rs1_data_o,
  output logic [31:0] rs2_data_o
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_i != 5'd0) begin
      regs[rd_i] <= wdata_i;
    end
  end

  // x0 is never written so it reads as zero
  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

endmodule

// File: hw/lsu.sv
module lsu import rv32_pkg::*; (
  input  logic        start_i,
  input  ctrl_t       ctrl_i,
  input  logic [31:0] addr_i,
  input  logic [31:0] store_data_i,
  output mem_req_t    data_req_o,
  input  logic [31:0] data_rdata_i,
  output logic [31:0] load_data_o
);

  logic [1:0]  offset;
  logic [3:0]  strb;
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  // IR and rs1 hold from MEM through MEMWAIT, so the offset of the
  // request cycle is still on addr_i when the data returns
  assign offset = addr_i[1:0];

  always_comb begin
    data_req_o.req  = start_i & (ctrl_i.dren | ctrl_i.dwen);
    data_req_o.we   = ctrl_i.dwen;
    data_req_o.addr = {addr_i[31:2], 2'b00};
    case (ctrl_i.load_type)
      LB, LBU: begin
        data_req_o.wdata = {4{store_data_i[7:0]}};
        strb             = 4'b0001 << offset;
      end
      LH, LHU: begin
        data_req_o.wdata = {2{store_data_i[15:0]}};
        strb             = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        data_req_o.wdata = store_data_i;
        strb             = 4'b1111;
      end
    endcase
    data_req_o.wstrb = ctrl_i.dwen ? strb : 4'b0000;
  end

  // Pick the addressed lane, then extend
  assign ld_byte = data_rdata_i[8*offset +: 8];
  assign ld_half = offset[1] ? data_rdata_i[31:16] : data_rdata_i[15:0];

  always_comb begin
    case (ctrl_i.load_type)
      LB:      load_data_o = {{24{ld_byte[7]}}, ld_byte};
      LBU:     load_data_o = {24'b0, ld_byte};
      LH:      load_data_o = {{16{ld_half[15]}}, ld_half};
      LHU:     load_data_o = {16'b0, ld_half};
      default: load_data_o = data_rdata_i;
    endcase
  end

endmodule

// File: hw/core_sequencer.sv
module core_sequencer import rv32_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        clk,
  input  logic        reset_i,
  output mem_req_t    fetch_req_o,
  input  logic [31:0] fetch_rdata_i,
  output instr_u      instr_o,
  input  ctrl_t       ctrl_i,
  input  logic [31:0] rs1_data_i,
  input  logic [31:0] rs2_data_i,
  output logic [31:0] alu_a_o,
  output logic [31:0] alu_b_o,
  input  logic [31:0] alu_result_i,
  input  logic        br_taken_i,
  input  logic [31:0] load_data_i,
  output logic        mem_start_o,
  output logic        rf_we_o,
  output logic [31:0] rf_wdata_o,
  output logic        halt_o,
  output logic        illegal_o
);

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH, S_DECODE, S_EXEC, S_MEM, S_MEMWAIT, S_HALTED, S_ILLEGAL
  } state_t;

  state_t      state;
  state_t      next_state;
  logic [31:0] pc;
  logic [31:0] next_pc;
  logic [31:0] pc_plus4;
  logic [31:0] pc_target;
  instr_u      ir;
  logic        mem_op;
  logic        pc_update;

  assign mem_op    = ctrl_i.dren | ctrl_i.dwen;
  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + ctrl_i.imm;

  // Decode the word straight off the bus in DECODE so a stop is caught early
  assign instr_o = (state == S_DECODE) ? instr_u'(fetch_rdata_i) : ir;

  always_comb begin
    next_state = state;
    case (state)
      S_IDLE:   next_state = S_FETCH;
      S_FETCH:  next_state = S_DECODE;
      S_DECODE: begin
        if (ctrl_i.illegal)
          next_state = S_ILLEGAL;
        else if (ctrl_i.halt)
          next_state = S_HALTED;
        else
          next_state = S_EXEC;
      end
      S_EXEC:    next_state = mem_op ? S_MEM : S_FETCH;
      S_MEM:     next_state = S_MEMWAIT;
      S_MEMWAIT: next_state = S_FETCH;
      default:   next_state = state;
    endcase
  end

  // JALR clears bit 0 of rs1+imm
  always_comb begin
    if (ctrl_i.jump)
      next_pc = ctrl_i.j_sel ? pc_target : {alu_result_i[31:1], 1'b0};
    else if (ctrl_i.branch && br_taken_i)
      next_pc = pc_target;
    else
      next_pc = pc_plus4;
  end

  assign pc_update = (state == S_EXEC && !mem_op) || state == S_MEMWAIT;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state <= S_IDLE;
      pc    <= RESET_PC;
    end else begin
      state <= next_state;
      if (pc_update)
        pc <= next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_DECODE)
      ir <= instr_u'(fetch_rdata_i);
  end

  always_comb begin
    fetch_req_o       = '0;
    fetch_req_o.req   = (state == S_FETCH);
    fetch_req_o.addr  = pc;
  end

  assign alu_a_o = (ctrl_i.alu_a_sel == A_PC) ? pc : rs1_data_i;
  assign alu_b_o = (ctrl_i.alu_b_sel == B_IMM) ? ctrl_i.imm : rs2_data_i;

  always_comb begin
    case (ctrl_i.w_sel)
      W_LOAD:  rf_wdata_o = load_data_i;
      W_PC4:   rf_wdata_o = pc_plus4;
      W_IMM:   rf_wdata_o = ctrl_i.imm;
      default: rf_wdata_o = alu_result_i;
    endcase
  end

  assign rf_we_o     = ctrl_i.wen && pc_update;
  assign mem_start_o = (state == S_MEM);
  assign halt_o      = (state == S_HALTED);
  assign illegal_o   = (state == S_ILLEGAL);

endmodule

// File: hw/mem_arbiter.sv
module mem_arbiter import rv32_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  mem_req_t    fetch_req_i,
  input  mem_req_t    data_req_i,
  output mem_req_t    mem_o,
  input  logic [31:0] mem_rdata_i,
  output logic [31:0] fetch_rdata_o,
  output logic [31:0] data_rdata_o
);

  logic data_sel;
  logic data_grant_q;

  // Data side wins a tie
  assign data_sel = data_req_i.req;
  assign mem_o    = data_sel ? data_req_i : fetch_req_i;

  always_ff @(posedge clk) begin
    if (reset_i)
      data_grant_q <= 1'b0;
    else if (mem_o.req)
      data_grant_q <= data_sel;
  end

  // Response belongs to whoever held the bus last cycle
  assign fetch_rdata_o = data_grant_q ? '0 : mem_rdata_i;
  assign data_rdata_o  = data_grant_q ? mem_rdata_i : '0;

endmodule

// File: hw/rv32_core.sv
module rv32_core import rv32_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        clk,
  input  logic        reset_i,
  output mem_req_t    mem_o,
  input  logic [31:0] mem_rdata_i,
  output logic        halt_o,
  output logic        illegal_o
);

  mem_req_t    fetch_req;
  mem_req_t    data_req;
  logic [31:0] fetch_rdata;
  logic [31:0] data_rdata;
  instr_u      instr;
  ctrl_t       ctrl;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic        br_taken;
  logic [31:0] load_data;
  logic        mem_start;
  logic        rf_we;
  logic [31:0] rf_wdata;

  core_sequencer #(
    .RESET_PC(RESET_PC)
  ) u_sequencer (
    .clk          (clk),
    .reset_i      (reset_i),
    .fetch_req_o  (fetch_req),
    .fetch_rdata_i(fetch_rdata),
    .instr_o      (instr),
    .ctrl_i       (ctrl),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .alu_a_o      (alu_a),
    .alu_b_o      (alu_b),
    .alu_result_i (alu_result),
    .br_taken_i   (br_taken),
    .load_data_i  (load_data),
    .mem_start_o  (mem_start),
    .rf_we_o      (rf_we),
    .rf_wdata_o   (rf_wdata),
    .halt_o       (halt_o),
    .illegal_o    (illegal_o)
  );

  control_unit u_control (
    .instr_i(instr),
    .ctrl_o (ctrl)
  );

  reg_file u_reg_file (
    .clk       (clk),
    .reset_i   (reset_i),
    .rs1_i     (ctrl.rs1),
    .rs2_i     (ctrl.rs2),
    .rd_i      (ctrl.rd),
    .we_i      (rf_we),
    .wdata_i   (rf_wdata),
    .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data)
  );

  alu u_alu (
    .op_i         (ctrl.alu_op),
    .a_i          (alu_a),
    .b_i          (alu_b),
    .branch_type_i(ctrl.branch_type),
    .rs1_i        (rs1_data),
    .rs2_i        (rs2_data),
    .result_o     (alu_result),
    .br_taken_o   (br_taken)
  );

  lsu u_lsu (
    .start_i     (mem_start),
    .ctrl_i      (ctrl),
    .addr_i      (alu_result),
    .store_data_i(rs2_data),
    .data_req_o  (data_req),
    .data_rdata_i(data_rdata),
    .load_data_o (load_data)
  );

  mem_arbiter u_arbiter (
    .clk          (clk),
    .reset_i      (reset_i),
    .fetch_req_i  (fetch_req),
    .data_req_i   (data_req),
    .mem_o        (mem_o),
    .mem_rdata_i  (mem_rdata_i),
    .fetch_rdata_o(fetch_rdata),
    .data_rdata_o (data_rdata)
  );

endmodule

// File: tb/rv32_core_chk.sv
module rv32_core_chk (
  input logic clk,
  input logic reset_i,
  input logic req_i,
  input logic halt_i,
  input logic illegal_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Read by the testbench summary
  int unsigned fail_count = 0;

  // Bus strobes last one cycle
  a_single_strobe: assert property (@(posedge clk) disable iff (reset_i)
    req_i |=> !req_i)
    else begin
      fail_count++;
      $error("mem_o.req high on two consecutive cycles");
    end

  a_quiet_when_stopped: assert property (@(posedge clk) disable iff (reset_i)
    (halt_i || illegal_i) |-> !req_i)
    else begin
      fail_count++;
      $error("memory request made while the core is stopped");
    end

  a_one_stop_kind: assert property (@(posedge clk) disable iff (reset_i)
    !(halt_i && illegal_i))
    else begin
      fail_count++;
      $error("halt_o and illegal_o high together");
    end

  // Reset takes effect one edge after it is sampled
  a_low_in_reset: assert property (@(posedge clk)
    reset_i |=> (!halt_i && !illegal_i))
    else begin
      fail_count++;
      $error("halt_o or illegal_o high during reset");
    end

endmodule

bind rv32_core rv32_core_chk u_chk (
  .clk      (clk),
  .reset_i  (reset_i),
  .req_i    (mem_o.req),
  .halt_i   (halt_o),
  .illegal_i(illegal_o)
);

// File: tb/tb_rv32_core.sv
module tb_rv32_core import rv32_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int    MEM_WORDS  = 1024;
  localparam int    STOP_WAIT  = 20;
  localparam string INPUT_FILE = "tb/program_input.txt";

  logic        clk;
  logic        reset_i;
  mem_req_t    mem_req;
  logic [31:0] mem_rdata;
  logic        halt;
  logic        illegal;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] prog_addr [$];
  logic [31:0] prog_word [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_word [$];

  int errors;
  int timeouts;
  int tests_run;

  rv32_core #(
    .RESET_PC(32'h0)
  ) u_dut (
    .clk        (clk),
    .reset_i    (reset_i),
    .mem_o      (mem_req),
    .mem_rdata_i(mem_rdata),
    .halt_o     (halt),
    .illegal_o  (illegal)
  );

  always #50 clk = ~clk;

  // Bus model: writes under wstrb, read data one cycle after the strobe
  always @(posedge clk) begin
    if (mem_req.req) begin
      if (mem_req.we) begin
        for (int b = 0; b < 4; b++) begin
          if (mem_req.wstrb[b])
            mem[mem_req.addr[11:2]][8*b +: 8] <= mem_req.wdata[8*b +: 8];
        end
      end else begin
        mem_rdata <= mem[mem_req.addr[11:2]];
      end
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("** Error at time %0t: %s is 0x%08h, expected 0x%08h",
               $time, name, actual, expected);
    end
  endtask

  task automatic load_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = '0;
    end
    for (int i = 0; i < prog_addr.size(); i++) begin
      mem[prog_addr[i][11:2]] = prog_word[i];
    end
  endtask

  task automatic run_test(input logic exp_halt, output logic timed_out);
    int limit;
    int cycles;
    limit     = prog_word.size() * 5 * 8 + 50;
    cycles    = 0;
    timed_out = 1'b0;
    @(posedge clk);
    reset_i <= 1'b1;
    repeat (2) @(posedge clk);
    // Core sits in IDLE here, bus is quiet
    load_memory();
    @(posedge clk);
    reset_i <= 1'b0;
    while (!halt && !illegal && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!halt && !illegal) begin
      timed_out = 1'b1;
      timeouts++;
      $display("Test %0d timed out after %0d cycles, neither halt_o nor illegal_o rose",
               tests_run + 1, cycles);
    end else begin
      // Stop must hold and memory must stay untouched
      repeat (STOP_WAIT) @(negedge clk);
      check_value("halt_o", halt, exp_halt);
      check_value("illegal_o", illegal, !exp_halt);
      for (int i = 0; i < exp_addr.size(); i++) begin
        check_value($sformatf("mem[0x%03h]", exp_addr[i]), mem[exp_addr[i][11:2]],
                    exp_word[i]);
      end
    end
  endtask

  initial begin
    int                fd;
    int                code;
    logic [127:0]      tag;
    logic [127:0]      kind;
    logic [31:0]       a;
    logic [31:0]       w;
    logic [8*256-1:0]  rest;
    logic              exp_halt;
    logic              timed_out;
    logic              done;

    clk       = 1'b0;
    reset_i   = 1'b1;
    mem_rdata = '0;
    errors    = 0;
    timeouts  = 0;
    tests_run = 0;
    exp_halt  = 1'b1;
    done      = 1'b0;

    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file %0s", INPUT_FILE);
      errors++;
      done = 1'b1;
    end

    while (!done) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        done = 1'b1;
      end else if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "T") begin
        code = $fscanf(fd, "%s", kind);
        exp_halt = (kind == "halt");
        if (kind != "halt" && kind != "illegal") begin
          $display("Unknown stop kind in test %0d of the stimulus file", tests_run + 1);
          errors++;
        end
        prog_addr.delete();
        prog_word.delete();
        exp_addr.delete();
        exp_word.delete();
      end else if (tag == "P") begin
        code = $fscanf(fd, "%h %h", a, w);
        prog_addr.push_back(a);
        prog_word.push_back(w);
      end else if (tag == "E") begin
        code = $fscanf(fd, "%h %h", a, w);
        exp_addr.push_back(a);
        exp_word.push_back(w);
      end else if (tag == "R") begin
        run_test(exp_halt, timed_out);
        tests_run++;
        if (timed_out)
          done = 1'b1;
      end else begin
        $display("Unknown record %0s in the stimulus file", tag);
        errors++;
        done = 1'b1;
      end
    end

    if (fd != 0)
      $fclose(fd);
    if (tests_run == 0) begin
      $display("No test was run");
      errors++;
    end
    errors += u_dut.u_chk.fail_count;

    $display("Tests run: %0d, errors: %0d, timeouts: %0d", tests_run, errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: build.f
hw/rv32_pkg.sv
hw/control_unit.sv
hw/alu.sv
hw/reg_file.sv
hw/lsu.sv
hw/core_sequencer.sv
hw/mem_arbiter.sv
hw/rv32_core.sv
tb/rv32_core_chk.sv
tb/tb_rv32_core.sv

// File: tb/program_input.txt
# T <halt|illegal> starts a test, P <addr> <word> loads a word, E <addr> <word> is expected
# R runs the test; addresses and words in hex, comment lines start with #
# ALU: sub, sra/srl, slt/sltu with negatives, xori, slli, srai, or
T halt
P 000 ff900093
P 004 00300113
P 008 402081b3
P 00c 4020d233
P 010 0020d2b3
P 014 0020a333
P 018 001133b3
P 01c 0f00c413
P 020 00411493
P 024 4010d513
P 028 0024e5b3
P 02c 20302023
P 030 20402223
P 034 20502423
P 038 20602623
P 03c 20702823
P 040 20802a23
P 044 20902c23
P 048 20a02e23
P 04c 22b02023
P 050 0000006f
E 200 fffffff6
E 204 ffffffff
E 208 1fffffff
E 20c 00000001
E 210 00000001
E 214 ffffff09
E 218 00000030
E 21c fffffffc
E 220 00000033
R
# Loads at every offset, byte and halfword stores merging into words
T halt
P 000 30300083
P 004 30204103
P 008 30100183
P 00c 30004203
P 010 30201283
P 014 30005303
P 018 30205383
P 01c 30200403
P 020 304002a3
P 024 30101323
P 028 30201423
P 02c 303005a3
P 030 30102823
P 034 30202a23
P 038 30302c23
P 03c 30402e23
P 040 32502023
P 044 32602223
P 048 32702423
P 04c 32802623
P 050 0000006f
P 300 80f17f01
P 304 11223344
P 308 55667788
E 300 80f17f01
E 304 ff800144
E 308 7f6600f1
E 310 ffffff80
E 314 000000f1
E 318 0000007f
E 31c 00000001
E 320 ffff80f1
E 324 00007f01
E 328 000080f1
E 32c fffffff1
R
# Branches taken and not taken, JAL and JALR links, LUI and AUIPC
T halt
P 000 00500093
P 004 ffd00113
P 008 00208463
P 00c 20102023
P 010 00114463
P 014 20202223
P 018 00116463
P 01c 20202423
P 020 008001ef
P 024 20102623
P 028 20302823
P 02c 03b00213
P 030 001202e7
P 034 20102a23
P 038 20102c23
P 03c 20502e23
P 040 12345337
P 044 00001397
P 048 22602023
P 04c 22702223
P 050 0020d463
P 054 22102423
P 058 00109463
P 05c 22102623
P 060 0000006f
E 200 00000005
E 204 00000000
E 208 fffffffd
E 20c 00000000
E 210 00000024
E 214 00000000
E 218 00000000
E 21c 00000034
E 220 12345000
E 224 00001044
E 228 00000000
E 22c 00000005
R
# SYSTEM instruction stops the core before the second store
T illegal
P 000 00900093
P 004 20102023
P 008 00000073
P 00c 20102223
P 010 0000006f
E 200 00000009
E 204 00000000
R
# Unknown opcode
T illegal
P 000 00900093
P 004 20102023
P 008 ffffffff
P 00c 20102223
P 010 0000006f
E 200 00000009
E 204 00000000
R
